// File: tm_depth_pkg.sv
/*
 * Shared definitions of the depth accumulator.
 * - level count and the ID width of each hierarchy level
 * - count width and enqueue FIFO depth
 * - count and clear address types
 * - state encoding of the init sequencer
 */
`default_nettype none

package tm_depth_pkg;

	localparam int NUM_LEVELS = 4;

	localparam int QUEUE_ID_W = 6;
	localparam int CONN_ID_W  = 5;
	localparam int GROUP_ID_W = 4;
	localparam int PORT_ID_W  = 3;

	// indexed by level: queue, connection, group, port.
	localparam int LEVEL_ID_W [NUM_LEVELS] = '{QUEUE_ID_W, CONN_ID_W, GROUP_ID_W, PORT_ID_W};

	localparam int MAX_ID_W = QUEUE_ID_W;   // init sweep covers the widest level.

	localparam int DEPTH_W        = 8;
	localparam int ENQ_FIFO_DEPTH = 4;

	typedef logic [DEPTH_W-1:0]  depth_t;
	typedef logic [MAX_ID_W-1:0] init_id_t;

	typedef enum logic [1:0] {
		INIT_IDLE,
		INIT_CLEAR,
		INIT_DONE
	} init_state_t;

endpackage

`default_nettype wire

// File: depth_op_if.sv
/*
 * One counter operation per cycle, arbiter to read-modify-write.
 * No ready signal, the sink takes every operation.
 */
`timescale 1ns/100ps
`default_nettype none

interface depth_op_if import tm_depth_pkg::*; #(
	parameter int ID_W = QUEUE_ID_W
) ();

	logic            valid;   // operation present.
	logic            dec;     // dequeue, count minus one.
	logic            clear;   // init write of zero.
	logic [ID_W-1:0] id;

	modport arb (output valid, dec, clear, id);
	modport rmw (input valid, dec, clear, id);

endinterface

`default_nettype wire

// File: depth_init_seq.sv
/*
 * Init sequencer.
 * Sweeps the clear address over all IDs once after reset,
 * then holds done and raises ready.
 */
`timescale 1ns/100ps
`default_nettype none

module depth_init_seq import tm_depth_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	output logic     init_busy,
	output init_id_t init_addr,
	output logic     ready
);

	init_state_t state;
	init_state_t next_state;

	always_comb begin
		next_state = state;
		case (state)
			INIT_IDLE:  next_state = INIT_CLEAR;
			INIT_CLEAR: if (&init_addr) next_state = INIT_DONE;   // last ID cleared.
			INIT_DONE:  next_state = INIT_DONE;
			default:    next_state = INIT_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= INIT_IDLE;
			init_addr <= '0;
			ready     <= 1'b0;
		end else begin
			state <= next_state;
			if (state == INIT_CLEAR)
				init_addr <= init_addr + init_id_t'(1);
			ready <= (state == INIT_DONE);   // one cycle behind done.
		end
	end

	assign init_busy = (state == INIT_CLEAR);

endmodule

`default_nettype wire

// File: depth_req_fifo.sv
/*
 * Small synchronous FIFO for the enqueue IDs of one level.
 * Circular buffer with read and write pointers and an occupancy count,
 * first-word fall-through output.
 */
`timescale 1ns/100ps
`default_nettype none

module depth_req_fifo import tm_depth_pkg::*; #(
	parameter int ID_W  = QUEUE_ID_W,
	parameter int DEPTH = ENQ_FIFO_DEPTH
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            push,
	input  logic [ID_W-1:0] din,
	input  logic            pop,
	output logic [ID_W-1:0] dout,
	output logic            empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [ID_W-1:0]  mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			case ({push, pop})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count;   // both or none.
			endcase
		end
	end

	assign dout  = mem[rd_ptr];   // head visible without a read.
	assign empty = (count == '0);

endmodule

`default_nettype wire

// File: depth_arbiter.sv
/*
 * Per-level arbiter.
 * Registers the request inputs, queues enqueue IDs in a FIFO and
 * picks one operation per cycle: clear during init, then dequeue,
 * then the oldest waiting enqueue.
 */
`timescale 1ns/100ps
`default_nettype none

module depth_arbiter import tm_depth_pkg::*; #(
	parameter int ID_W = QUEUE_ID_W
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            init_busy,
	input  init_id_t        init_addr,
	input  logic            enq,
	input  logic [ID_W-1:0] enq_id,
	input  logic            deq,
	input  logic [ID_W-1:0] deq_id,
	depth_op_if.arb         op
);

	logic            enq_r;
	logic [ID_W-1:0] enq_id_r;
	logic            deq_r;
	logic [ID_W-1:0] deq_id_r;
	logic            fifo_pop;
	logic            fifo_empty;
	logic [ID_W-1:0] fifo_dout;

	always_ff @(posedge clk) begin
		if (reset) begin
			enq_r <= 1'b0;
			deq_r <= 1'b0;
		end else begin
			enq_r <= enq;
			deq_r <= deq;
		end
	end

	always_ff @(posedge clk) begin
		enq_id_r <= enq_id;
		deq_id_r <= deq_id;
	end

	depth_req_fifo #(
		.ID_W  (ID_W),
		.DEPTH (ENQ_FIFO_DEPTH)
	) fifo0 (
		.clk   (clk),
		.reset (reset),
		.push  (enq_r),
		.din   (enq_id_r),
		.pop   (fifo_pop),
		.dout  (fifo_dout),
		.empty (fifo_empty)
	);

	// a dequeue always wins over a waiting enqueue.
	assign fifo_pop = !init_busy && !deq_r && !fifo_empty;

	assign op.valid = init_busy || deq_r || !fifo_empty;
	assign op.clear = init_busy;
	assign op.dec   = !init_busy && deq_r;

	always_comb begin
		if (init_busy)
			op.id = init_addr[ID_W-1:0];   // low bits for this level.
		else if (deq_r)
			op.id = deq_id_r;
		else
			op.id = fifo_dout;
	end

endmodule

`default_nettype wire

// File: depth_counter_ram.sv
/*
 * One-read one-write synchronous memory.
 * Read data one cycle after the address; a read and a write to
 * the same address in one cycle return the old word.
 */
`timescale 1ns/100ps
`default_nettype none

module depth_counter_ram #(
	parameter int ADDR_W = 6,
	parameter int DATA_W = 8
) (
	input  logic              clk,
	input  logic              wr,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [DATA_W-1:0] din,
	input  logic [ADDR_W-1:0] raddr,
	output logic [DATA_W-1:0] dout
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= din;
		dout <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: depth_rmw.sv
/*
 * Per-level read-modify-write of the count memory.
 * stage 0 reads, stage 1 forwards and updates, stage 2 writes.
 * Ack and the new count of an enqueue leave one cycle after the write.
 */
`timescale 1ns/100ps
`default_nettype none

module depth_rmw import tm_depth_pkg::*; #(
	parameter int ID_W = QUEUE_ID_W
) (
	input  logic    clk,
	input  logic    reset,
	depth_op_if.rmw op,
	output logic    ack,
	output depth_t  depth
);

	logic            s1_valid;
	logic            s1_dec;
	logic            s1_clear;
	logic [ID_W-1:0] s1_id;
	logic            fwd_near;   // stage 2 holds the same ID.
	logic            fwd_far;    // write of the cycle before.
	depth_t          ram_dout;
	depth_t          cur_cnt;
	depth_t          new_cnt;
	logic            s2_valid;
	logic            s2_enq;
	logic [ID_W-1:0] s2_id;
	depth_t          s2_wdata;
	depth_t          s3_wdata;

	depth_counter_ram #(
		.ADDR_W (ID_W),
		.DATA_W (DEPTH_W)
	) ram0 (
		.clk   (clk),
		.wr    (s2_valid),
		.waddr (s2_id),
		.din   (s2_wdata),
		.raddr (op.id),
		.dout  (ram_dout)
	);

	// freshest value wins, the memory word may be two writes stale.
	assign cur_cnt = fwd_near ? s2_wdata :
		fwd_far ? s3_wdata :
		ram_dout;

	always_comb begin
		if (s1_clear)
			new_cnt = '0;
		else if (s1_dec)
			new_cnt = cur_cnt - depth_t'(1);
		else
			new_cnt = cur_cnt + depth_t'(1);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s2_enq   <= 1'b0;
			ack      <= 1'b0;
		end else begin
			s1_valid <= op.valid;
			s2_valid <= s1_valid;
			s2_enq   <= s1_valid && !s1_dec && !s1_clear;
			ack      <= s2_enq;
		end
	end

	always_ff @(posedge clk) begin
		s1_dec   <= op.dec;
		s1_clear <= op.clear;
		s1_id    <= op.id;
		fwd_near <= s1_valid && (s1_id == op.id);   // sampled with the read.
		fwd_far  <= s2_valid && (s2_id == op.id);
		s2_id    <= s1_id;
		s2_wdata <= new_cnt;
		s3_wdata <= s2_wdata;
		if (s2_enq)
			depth <= s2_wdata;   // count after the increment.
	end

endmodule

`default_nettype wire

// File: tm_depth_acc.sv
/*
 * Depth accumulator top level.
 * Init sequencer plus one arbiter and read-modify-write slice per
 * hierarchy level: queue, connection, connection group, port queue.
 */
`timescale 1ns/100ps
`default_nettype none

module tm_depth_acc import tm_depth_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	output logic                  ready,

	input  logic                  queue_enq,
	input  logic [QUEUE_ID_W-1:0] queue_id,
	input  logic                  conn_enq,
	input  logic [CONN_ID_W-1:0]  conn_id,
	input  logic                  group_enq,
	input  logic [GROUP_ID_W-1:0] group_id,
	input  logic                  port_enq,
	input  logic [PORT_ID_W-1:0]  port_id,

	input  logic                  deq,
	input  logic [QUEUE_ID_W-1:0] deq_queue_id,
	input  logic [CONN_ID_W-1:0]  deq_conn_id,
	input  logic [GROUP_ID_W-1:0] deq_group_id,
	input  logic [PORT_ID_W-1:0]  deq_port_id,

	output logic                  queue_ack,
	output depth_t                queue_depth,
	output logic                  conn_ack,
	output depth_t                conn_depth,
	output logic                  group_ack,
	output depth_t                group_depth,
	output logic                  port_ack,
	output depth_t                port_depth
);

	logic                  init_busy;
	init_id_t              init_addr;
	logic [NUM_LEVELS-1:0] lvl_enq;
	logic [NUM_LEVELS-1:0] lvl_ack;
	logic [MAX_ID_W-1:0]   lvl_enq_id [NUM_LEVELS];   // zero extended IDs.
	logic [MAX_ID_W-1:0]   lvl_deq_id [NUM_LEVELS];
	depth_t                lvl_depth  [NUM_LEVELS];

	assign lvl_enq = {port_enq, group_enq, conn_enq, queue_enq};

	assign lvl_enq_id[0] = queue_id;
	assign lvl_enq_id[1] = MAX_ID_W'(conn_id);
	assign lvl_enq_id[2] = MAX_ID_W'(group_id);
	assign lvl_enq_id[3] = MAX_ID_W'(port_id);

	assign lvl_deq_id[0] = deq_queue_id;
	assign lvl_deq_id[1] = MAX_ID_W'(deq_conn_id);
	assign lvl_deq_id[2] = MAX_ID_W'(deq_group_id);
	assign lvl_deq_id[3] = MAX_ID_W'(deq_port_id);

	depth_init_seq init0 (
		.clk       (clk),
		.reset     (reset),
		.init_busy (init_busy),
		.init_addr (init_addr),
		.ready     (ready)
	);

	for (genvar g = 0; g < NUM_LEVELS; g++) begin : lvl
		depth_op_if #(.ID_W(LEVEL_ID_W[g])) op_if ();

		depth_arbiter #(.ID_W(LEVEL_ID_W[g])) arb0 (
			.clk       (clk),
			.reset     (reset),
			.init_busy (init_busy),
			.init_addr (init_addr),
			.enq       (lvl_enq[g]),
			.enq_id    (lvl_enq_id[g][LEVEL_ID_W[g]-1:0]),
			.deq       (deq),   // one dequeue hits every level.
			.deq_id    (lvl_deq_id[g][LEVEL_ID_W[g]-1:0]),
			.op        (op_if.arb)
		);

		depth_rmw #(.ID_W(LEVEL_ID_W[g])) rmw0 (
			.clk   (clk),
			.reset (reset),
			.op    (op_if.rmw),
			.ack   (lvl_ack[g]),
			.depth (lvl_depth[g])
		);
	end

	assign {port_ack, group_ack, conn_ack, queue_ack} = lvl_ack;

	assign queue_depth = lvl_depth[0];
	assign conn_depth  = lvl_depth[1];
	assign group_depth = lvl_depth[2];
	assign port_depth  = lvl_depth[3];

endmodule

`default_nettype wire

// File: tb_depth_model.svh
/*
 * Count model for the depth accumulator testbench.
 * - per-level count arrays, waiting enqueues and expected depths
 * - per-cycle ordering: the dequeue of the cycle before wins
 * - reference function for the depth that an enqueue returns
 */

localparam int SLOTS = 16;

depth_t model_cnt  [NUM_LEVELS][2**MAX_ID_W];
int     pend_id    [NUM_LEVELS][SLOTS];   // enqueues not yet applied.
int     pend_cyc   [NUM_LEVELS][SLOTS];   // request cycle of each.
int     pend_wr    [NUM_LEVELS];
int     pend_rd    [NUM_LEVELS];
depth_t exp_depth  [NUM_LEVELS][SLOTS];
int     exp_wr     [NUM_LEVELS];
int     exp_rd     [NUM_LEVELS];
logic   deq_due;                          // dequeue from the cycle before.
int     deq_due_id [NUM_LEVELS];

// depth reported by an enqueue that finds this count.
function automatic depth_t expected_depth(input depth_t count);
	return count + depth_t'(1);
endfunction

task automatic clear_counts();
	for (int l = 0; l < NUM_LEVELS; l++) begin
		for (int i = 0; i < 2**MAX_ID_W; i++)
			model_cnt[l][i] = '0;   // init sweep leaves zeros.
		pend_wr[l] = 0;
		pend_rd[l] = 0;
		exp_wr[l]  = 0;
		exp_rd[l]  = 0;
	end
	deq_due = 1'b0;
endtask

// one operation per level and cycle, an enqueue waits at least two cycles.
task automatic apply_cycle_ops(input int cyc);
	int id;
	for (int l = 0; l < NUM_LEVELS; l++) begin
		if (deq_due) begin
			model_cnt[l][deq_due_id[l]] = model_cnt[l][deq_due_id[l]] - depth_t'(1);
		end else if (pend_rd[l] != pend_wr[l] && pend_cyc[l][pend_rd[l] % SLOTS] <= cyc - 2) begin
			id = pend_id[l][pend_rd[l] % SLOTS];
			model_cnt[l][id] = expected_depth(model_cnt[l][id]);
			exp_depth[l][exp_wr[l] % SLOTS] = model_cnt[l][id];
			exp_wr[l]++;
			pend_rd[l]++;
		end
	end
	deq_due = 1'b0;
endtask

task automatic record_requests(input int cyc);
	for (int l = 0; l < NUM_LEVELS; l++) begin
		if (req_enq[l]) begin
			pend_id[l][pend_wr[l] % SLOTS]  = int'(req_id[l]);
			pend_cyc[l][pend_wr[l] % SLOTS] = cyc;
			pend_wr[l]++;
		end
		deq_due_id[l] = int'(req_deq_id[l]);
	end
	deq_due = req_deq;
endtask

// File: tb_tm_depth_acc.sv
/*
 * Testbench of the depth accumulator.
 * Clock, reset, directed and random enqueue and dequeue stimulus,
 * ack collection against the count model, per-test and total counts.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_tm_depth_acc import tm_depth_pkg::*; ();

	localparam int READY_TIMEOUT = 200;
	localparam int ACK_TIMEOUT   = 200;

	logic                  clk;
	logic                  reset;
	logic                  ready;
	logic                  queue_enq;
	logic [QUEUE_ID_W-1:0] queue_id;
	logic                  conn_enq;
	logic [CONN_ID_W-1:0]  conn_id;
	logic                  group_enq;
	logic [GROUP_ID_W-1:0] group_id;
	logic                  port_enq;
	logic [PORT_ID_W-1:0]  port_id;
	logic                  deq;
	logic [QUEUE_ID_W-1:0] deq_queue_id;
	logic [CONN_ID_W-1:0]  deq_conn_id;
	logic [GROUP_ID_W-1:0] deq_group_id;
	logic [PORT_ID_W-1:0]  deq_port_id;
	logic                  queue_ack;
	depth_t                queue_depth;
	logic                  conn_ack;
	depth_t                conn_depth;
	logic                  group_ack;
	depth_t                group_depth;
	logic                  port_ack;
	depth_t                port_depth;

	logic [NUM_LEVELS-1:0] req_enq;   // requests of the next cycle.
	logic [MAX_ID_W-1:0]   req_id     [NUM_LEVELS];
	logic                  req_deq;
	logic [MAX_ID_W-1:0]   req_deq_id [NUM_LEVELS];
	logic [NUM_LEVELS-1:0] ack_vec;
	depth_t                depth_vec  [NUM_LEVELS];
	depth_t                last_depth [NUM_LEVELS];
	int                    enq_cnt    [NUM_LEVELS];
	int                    ack_cnt    [NUM_LEVELS];
	int                    cyc;
	int                    errors;
	int                    checks;
	int                    tests;
	int                    test_err0;
	string                 test_name;

	`include "tb_depth_model.svh"

	tm_depth_acc dut0 (.*);

	assign ack_vec      = {port_ack, group_ack, conn_ack, queue_ack};
	assign depth_vec[0] = queue_depth;
	assign depth_vec[1] = conn_depth;
	assign depth_vec[2] = group_depth;
	assign depth_vec[3] = port_depth;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_ack(input int lvl, input depth_t actual);
		ack_cnt[lvl]++;
		last_depth[lvl] = actual;
		assert (exp_rd[lvl] != exp_wr[lvl]) else begin
			$display("level %0d gave an ack with no enqueue waiting for it", lvl);
			errors++;
		end
		if (exp_rd[lvl] != exp_wr[lvl]) begin
			check_value($sformatf("level %0d depth", lvl), exp_depth[lvl][exp_rd[lvl] % SLOTS],
				actual);
			exp_rd[lvl]++;
		end
	endtask

	// acks are stable around the falling edge.
	always @(negedge clk) begin
		if (!reset) begin
			for (int l = 0; l < NUM_LEVELS; l++) begin
				if (ack_vec[l])
					check_ack(l, depth_vec[l]);
			end
		end
	end

	task automatic start_cycle();
		@(posedge clk);
		#1;
		cyc++;
		apply_cycle_ops(cyc);
	endtask

	task automatic send_requests();
		queue_enq    = req_enq[0];
		queue_id     = req_id[0][QUEUE_ID_W-1:0];
		conn_enq     = req_enq[1];
		conn_id      = req_id[1][CONN_ID_W-1:0];
		group_enq    = req_enq[2];
		group_id     = req_id[2][GROUP_ID_W-1:0];
		port_enq     = req_enq[3];
		port_id      = req_id[3][PORT_ID_W-1:0];
		deq          = req_deq;
		deq_queue_id = req_deq_id[0][QUEUE_ID_W-1:0];
		deq_conn_id  = req_deq_id[1][CONN_ID_W-1:0];
		deq_group_id = req_deq_id[2][GROUP_ID_W-1:0];
		deq_port_id  = req_deq_id[3][PORT_ID_W-1:0];
		record_requests(cyc);
		for (int l = 0; l < NUM_LEVELS; l++)
			enq_cnt[l] += int'(req_enq[l]);
		req_enq = '0;
		req_deq = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			start_cycle();
			send_requests();
		end
	endtask

	task automatic set_enq(input int lvl, input int id);
		req_enq[lvl] = 1'b1;
		req_id[lvl]  = MAX_ID_W'(id % (1 << LEVEL_ID_W[lvl]));
	endtask

	function automatic logic [MAX_ID_W-1:0] random_id(input int lvl);
		return MAX_ID_W'($urandom_range((1 << LEVEL_ID_W[lvl]) - 1, 0));
	endfunction

	// a dequeue only where every level has a positive count.
	task automatic try_dequeue();
		logic [MAX_ID_W-1:0] id;
		logic                found;
		for (int l = 0; l < NUM_LEVELS; l++) begin
			found = 1'b0;
			for (int t = 0; t < 8 && !found; t++) begin
				id = random_id(l);
				if (model_cnt[l][id] != '0) begin
					req_deq_id[l] = id;
					found         = 1'b1;
				end
			end
			if (!found)
				return;
		end
		req_deq = 1'b1;
	endtask

	function automatic logic all_acked();
		for (int l = 0; l < NUM_LEVELS; l++) begin
			if (ack_cnt[l] != enq_cnt[l])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic end_run();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (ready !== 1'b1 && n < READY_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (ready !== 1'b1) begin
			$display("ready did not rise within %0d cycles after reset", READY_TIMEOUT);
			errors++;
			end_run();
		end
	endtask

	task automatic wait_acks();
		int n;
		n = 0;
		while (!all_acked() && n < ACK_TIMEOUT) begin
			idle_cycles(1);
			n++;
		end
		if (!all_acked()) begin
			$display("acks still missing after %0d cycles in test %s", ACK_TIMEOUT, test_name);
			errors++;
			end_run();
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic finish_test();
		idle_cycles(8);   // room for a stray ack.
		for (int l = 0; l < NUM_LEVELS; l++) begin
			assert (ack_cnt[l] == enq_cnt[l]) else begin
				$display("level %0d gave %0d acks for %0d enqueues in test %s", l, ack_cnt[l],
					enq_cnt[l], test_name);
				errors++;
			end
		end
		tests++;
		$display("test %-12s %0d errors", test_name, errors - test_err0);
	endtask

	initial begin
		int     k;
		depth_t base [NUM_LEVELS];
		void'($urandom(23));
		reset   = 1'b1;
		req_enq = '0;
		req_deq = 1'b0;
		for (int l = 0; l < NUM_LEVELS; l++) begin
			req_id[l]     = '0;
			req_deq_id[l] = '0;
			enq_cnt[l]    = 0;
			ack_cnt[l]    = 0;
		end
		cyc    = 0;
		errors = 0;
		checks = 0;
		tests  = 0;
		clear_counts();
		send_requests();   // all inputs idle.
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (ready === 1'b0) else begin
			$display("ready is high right after reset");
			errors++;
		end
		wait_ready();

		begin_test("clear");
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 4; i++) begin
				start_cycle();
				k = r * 4 + i;
				set_enq(0, k * 9);
				set_enq(1, k * 7 + 3);
				set_enq(2, k * 5 + 1);
				set_enq(3, k);
				send_requests();
			end
			wait_acks();
			for (int l = 0; l < NUM_LEVELS; l++)
				check_value($sformatf("level %0d first count", l), 1, last_depth[l]);
		end
		finish_test();

		begin_test("forwarding");
		for (int i = 0; i < 4; i++) begin
			start_cycle();
			set_enq(0, 40);
			send_requests();
		end
		wait_acks();
		check_value("fourth count", 4, last_depth[0]);
		finish_test();

		begin_test("dequeue");
		base[0] = model_cnt[0][5];
		base[1] = model_cnt[1][9];
		base[2] = model_cnt[2][3];
		base[3] = model_cnt[3][6];
		for (int i = 0; i < 2; i++) begin
			start_cycle();
			set_enq(0, 5);
			set_enq(1, 9);
			set_enq(2, 3);
			set_enq(3, 6);
			send_requests();
		end
		wait_acks();
		idle_cycles(8);
		start_cycle();
		req_deq       = 1'b1;
		req_deq_id[0] = 5;
		req_deq_id[1] = 9;
		req_deq_id[2] = 3;
		req_deq_id[3] = 6;
		send_requests();
		idle_cycles(8);
		start_cycle();
		set_enq(0, 5);
		set_enq(1, 9);
		set_enq(2, 3);
		set_enq(3, 6);
		send_requests();
		wait_acks();
		for (int l = 0; l < NUM_LEVELS; l++)
			check_value($sformatf("level %0d count", l), depth_t'(base[l] + 2), last_depth[l]);
		finish_test();

		begin_test("deq priority");
		base[0] = model_cnt[0][5];
		for (int i = 0; i < 3; i++) begin
			start_cycle();
			set_enq(0, 5);
			if (i == 1) begin   // lands while enqueues wait.
				req_deq       = 1'b1;
				req_deq_id[0] = 5;
				req_deq_id[1] = 9;
				req_deq_id[2] = 3;
				req_deq_id[3] = 6;
			end
			send_requests();
		end
		wait_acks();
		start_cycle();
		set_enq(0, 5);
		send_requests();
		wait_acks();
		check_value("probe count", depth_t'(base[0] + 3 - 1 + 1), last_depth[0]);
		finish_test();

		begin_test("random mix");
		for (int c = 0; c < 400; c++) begin
			start_cycle();
			for (int l = 0; l < NUM_LEVELS; l++) begin
				if (enq_cnt[l] - ack_cnt[l] < ENQ_FIFO_DEPTH && $urandom_range(1, 0) == 1)
					set_enq(l, random_id(l));
			end
			if ($urandom_range(3, 0) == 0)
				try_dequeue();
			send_requests();
		end
		wait_acks();
		finish_test();

		end_run();
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
tm_depth_pkg.sv
depth_op_if.sv
depth_init_seq.sv
depth_req_fifo.sv
depth_arbiter.sv
depth_counter_ram.sv
depth_rmw.sv
tm_depth_acc.sv
tb_tm_depth_acc.sv

// File: Bender.yml
package:
  name: tm_depth_acc

sources:
  - files:
      - tm_depth_pkg.sv
      - depth_op_if.sv
      - depth_init_seq.sv
      - depth_req_fifo.sv
      - depth_arbiter.sv
      - depth_counter_ram.sv
      - depth_rmw.sv
      - tm_depth_acc.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tm_depth_acc.sv
